//--- logic/sched_settings.svh
// Task scheduler settings
`ifndef SCHED_SETTINGS_SVH
`define SCHED_SETTINGS_SVH

// Cluster size
`define NUM_ACCS            4
`define SUBQUEUE_LEN        16
`define NUM_ACC_TYPES       2

// Accelerator type table, each type owns a contiguous range of accelerators
`define TYPE0_CODE          64'h0000_0000_1234_0001
`define TYPE0_BASE          0
`define TYPE0_COUNT         3
`define TYPE1_CODE          64'h0000_0000_5678_0002
`define TYPE1_BASE          3
`define TYPE1_COUNT         1

// Task and command header fields
`define NUM_ARGS_OFFSET     8
`define TASK_ID_GIVEN_BIT   0
`define ENTRY_VALID_BIT     0
`define CMD_TYPE_OFFSET     24
`define CMD_TYPE_EXEC       8'h01

// Argument flag word
`define ARG_IDX_OFFSET      32
`define ARG_FLAG_OFFSET     4
`define DEFAULT_ARG_FLAGS   2'b11

`define ACK_OK_CODE         8'h01
`define ACK_REJECT_CODE     8'h00
`define GEN_ID_PREFIX       32'hf000_0000
`define HEADER_SLOTS        3

`endif

//--- logic/sched_pkg.sv
// Scheduler shared types
`default_nettype none

`include "sched_settings.svh"

package sched_pkg;

    // Accelerator number
    typedef logic [$clog2(`NUM_ACCS)-1:0] acc_id_t;

    // Ring position inside one subqueue
    typedef logic [$clog2(`SUBQUEUE_LEN)-1:0] slot_idx_t;

    // One extra bit so a completely free ring can be counted
    typedef logic [$clog2(`SUBQUEUE_LEN):0] slot_cnt_t;

    typedef logic [3:0] arg_cnt_t;

    // Stream and command queue word
    typedef logic [63:0] word_t;

    typedef logic [7:0] ack_t;

endpackage

`default_nettype wire

//--- logic/acc_selector.sv
// Round-robin accelerator selector
`timescale 1ns/10ps
`default_nettype none

`include "sched_settings.svh"

module acc_selector (
    input  wire                      clk,
    input  wire                      rstn,
    input  wire                      sel_req,
    input  wire sched_pkg::word_t    sel_type,
    output sched_pkg::acc_id_t       sel_acc
);

    localparam int TYPE_BITS = (`NUM_ACC_TYPES > 1) ? $clog2(`NUM_ACC_TYPES) : 1;

    localparam sched_pkg::word_t   TYPE_CODE [`NUM_ACC_TYPES] = '{`TYPE0_CODE, `TYPE1_CODE};
    localparam sched_pkg::acc_id_t TYPE_BASE [`NUM_ACC_TYPES] = '{`TYPE0_BASE, `TYPE1_BASE};
    localparam sched_pkg::acc_id_t TYPE_LAST [`NUM_ACC_TYPES] =
        '{`TYPE0_COUNT - 1, `TYPE1_COUNT - 1};

    sched_pkg::acc_id_t   offset [`NUM_ACC_TYPES];
    logic [TYPE_BITS-1:0] hit_idx;

    // Unknown codes fall back to the first table entry
    always_comb begin
        hit_idx = '0;
        for (int t = 0; t < `NUM_ACC_TYPES; t++) begin
            if (sel_type == TYPE_CODE[t]) hit_idx = TYPE_BITS'(t);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            sel_acc <= '0;
            for (int t = 0; t < `NUM_ACC_TYPES; t++) offset[t] <= '0;
        end else if (sel_req) begin
            sel_acc <= TYPE_BASE[hit_idx] + offset[hit_idx];
            if (offset[hit_idx] == TYPE_LAST[hit_idx]) begin
                offset[hit_idx] <= '0;
            end else begin
                offset[hit_idx] <= offset[hit_idx] + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/subqueue_tracker.sv
// Subqueue ring tracker
`timescale 1ns/10ps
`default_nettype none

`include "sched_settings.svh"

module subqueue_tracker #(
    parameter int ACC_NUM = 0
) (
    input  wire                        clk,
    input  wire                        rstn,
    input  wire                        reserve_req,
    input  wire sched_pkg::acc_id_t    reserve_acc,
    input  wire sched_pkg::slot_cnt_t  reserve_slots,
    input  wire                        retire_valid,
    input  wire sched_pkg::acc_id_t    retire_acc,
    input  wire sched_pkg::slot_cnt_t  retire_slots,
    output logic                       fits,
    output sched_pkg::slot_idx_t       base_idx
);

    sched_pkg::slot_idx_t wr_idx;
    sched_pkg::slot_cnt_t free_cnt;
    sched_pkg::slot_cnt_t take;
    sched_pkg::slot_cnt_t give;
    logic                 grant;

    assign fits     = reserve_slots <= free_cnt;
    assign grant    = reserve_req && fits && reserve_acc == sched_pkg::acc_id_t'(ACC_NUM);
    assign base_idx = wr_idx;

    // A reservation and a retire may hit the same cycle
    assign take = grant ? reserve_slots : '0;
    assign give = (retire_valid && retire_acc == sched_pkg::acc_id_t'(ACC_NUM)) ?
                  retire_slots : '0;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_idx   <= '0;
            free_cnt <= sched_pkg::slot_cnt_t'(`SUBQUEUE_LEN);
        end else begin
            if (grant) wr_idx <= wr_idx + sched_pkg::slot_idx_t'(reserve_slots);
            free_cnt <= free_cnt - take + give;
        end
    end

endmodule

`default_nettype wire

//--- logic/cmd_queue_writer.sv
// Command queue writer
`timescale 1ns/10ps
`default_nettype none

`include "sched_settings.svh"

module cmd_queue_writer (
    input  wire                        clk,
    input  wire                        rstn,
    input  wire                        cmd_start,
    input  wire sched_pkg::acc_id_t    reserve_acc,
    input  wire sched_pkg::slot_idx_t  base_idx [`NUM_ACCS],
    input  wire                        word_valid,
    input  wire sched_pkg::word_t      word_data,
    input  wire                        cmd_done,
    input  wire sched_pkg::word_t      cmd_header,
    output logic [$bits(sched_pkg::acc_id_t)+$bits(sched_pkg::slot_idx_t)-1:0] cmdq_addr,
    output logic                       cmdq_en,
    output sched_pkg::word_t           cmdq_din,
    output logic                       nempty_write,
    output sched_pkg::acc_id_t         nempty_acc
);

    sched_pkg::acc_id_t   acc;
    sched_pkg::slot_idx_t base;
    sched_pkg::slot_idx_t body_idx;
    sched_pkg::word_t     hdr_word;
    logic                 hdr_written;

    always_comb begin
        hdr_word = cmd_header;
        hdr_word[`ENTRY_VALID_BIT] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            cmdq_en      <= 1'b0;
            hdr_written  <= 1'b0;
            nempty_write <= 1'b0;
        end else begin
            cmdq_en      <= word_valid || cmd_done;
            hdr_written  <= cmd_done;
            nempty_write <= hdr_written;
        end
    end

    // Body fills base+1 onward and wraps in the ring, header goes to base last
    always_ff @(posedge clk) begin
        if (cmd_start) begin
            acc      <= reserve_acc;
            base     <= base_idx[reserve_acc];
            body_idx <= base_idx[reserve_acc] + 1'b1;
        end
        if (word_valid) begin
            cmdq_addr <= {acc, body_idx};
            cmdq_din  <= word_data;
            body_idx  <= body_idx + 1'b1;
        end
        if (cmd_done) begin
            cmdq_addr <= {acc, base};
            cmdq_din  <= hdr_word;
        end
        if (hdr_written) nempty_acc <= acc;
    end

endmodule

`default_nettype wire

//--- logic/task_dispatcher.sv
// Task stream dispatcher
`timescale 1ns/10ps
`default_nettype none

`include "sched_settings.svh"

module task_dispatcher (
    input  wire                        clk,
    input  wire                        rstn,
    input  wire sched_pkg::word_t      in_data,
    input  wire                        in_valid,
    input  wire                        in_last,
    input  wire sched_pkg::acc_id_t    in_src,
    output logic                       in_ready,
    output sched_pkg::word_t           out_data,
    output logic                       out_valid,
    input  wire                        out_ready,
    output sched_pkg::acc_id_t         out_dest,
    output logic                       sel_req,
    output sched_pkg::word_t           sel_type,
    input  wire sched_pkg::acc_id_t    sel_acc,
    output logic                       reserve_req,
    output sched_pkg::acc_id_t         reserve_acc,
    output sched_pkg::slot_cnt_t       reserve_slots,
    input  wire [`NUM_ACCS-1:0]        fits,
    output logic                       cmd_start,
    output logic                       word_valid,
    output sched_pkg::word_t           word_data,
    output logic                       cmd_done,
    output sched_pkg::word_t           cmd_header
);

    typedef enum logic [3:0] {
        S_IDLE, S_HEADER, S_TASK_ID, S_PARENT, S_TYPE, S_SELECT, S_WR_TID, S_WR_PID,
        S_ARG_FLAG, S_ARG_VAL, S_WR_HDR, S_DRAIN, S_FLUSH, S_ACK
    } state_t;

    state_t               state;
    sched_pkg::acc_id_t   src;
    sched_pkg::arg_cnt_t  nargs;
    sched_pkg::arg_cnt_t  arg_idx;
    sched_pkg::word_t     task_id;
    sched_pkg::word_t     parent_id;
    sched_pkg::word_t     arg_buf;
    sched_pkg::word_t     flag_word;
    sched_pkg::ack_t      ack_code;
    logic                 type_last;
    logic                 ack_ok;
    logic [31:0]          gen_cnt;
    logic [5:0]           need_slots;

    assign in_ready = state inside {S_HEADER, S_TASK_ID, S_PARENT, S_TYPE, S_ARG_FLAG, S_DRAIN};

    assign sel_req  = state == S_TYPE && in_valid;
    assign sel_type = in_data;

    // Oversized commands ask for more than a ring holds so they never fit
    assign need_slots    = 6'(`HEADER_SLOTS) + {1'b0, nargs, 1'b0};
    assign reserve_slots = (need_slots > 6'(`SUBQUEUE_LEN)) ?
                           sched_pkg::slot_cnt_t'(`SUBQUEUE_LEN + 1) :
                           sched_pkg::slot_cnt_t'(need_slots);
    assign reserve_req   = state == S_SELECT;
    assign reserve_acc   = sel_acc;
    assign cmd_start     = reserve_req && fits[sel_acc];

    always_comb begin
        flag_word = '0;
        flag_word[`ARG_IDX_OFFSET +: 4]  = arg_idx;
        flag_word[`ARG_FLAG_OFFSET +: 2] = `DEFAULT_ARG_FLAGS;
        cmd_header = '0;
        cmd_header[`CMD_TYPE_OFFSET +: 8] = `CMD_TYPE_EXEC;
        cmd_header[`NUM_ARGS_OFFSET +: 4] = nargs;
    end

    always_comb begin
        word_valid = 1'b0;
        word_data  = task_id;
        case (state)
            S_WR_TID: word_valid = 1'b1;
            S_WR_PID: begin
                word_valid = 1'b1;
                word_data  = parent_id;
            end
            S_ARG_FLAG: begin
                word_valid = in_valid;
                word_data  = flag_word;
            end
            S_ARG_VAL: begin
                word_valid = 1'b1;
                word_data  = arg_buf;
            end
            default: ;
        endcase
    end

    assign cmd_done  = state == S_WR_HDR;
    assign ack_code  = ack_ok ? `ACK_OK_CODE : `ACK_REJECT_CODE;
    assign out_data  = {56'd0, ack_code};
    assign out_valid = state == S_ACK;
    assign out_dest  = src;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state   <= S_IDLE;
            gen_cnt <= '0;
        end else begin
            case (state)
                S_IDLE:    state <= S_HEADER;
                S_HEADER: begin
                    if (in_valid) begin
                        state <= in_data[`TASK_ID_GIVEN_BIT] ? S_TASK_ID : S_PARENT;
                    end
                end
                S_TASK_ID: if (in_valid) state <= S_PARENT;
                S_PARENT:  if (in_valid) state <= S_TYPE;
                S_TYPE:    if (in_valid) state <= S_SELECT;
                S_SELECT: begin
                    if (fits[sel_acc]) begin
                        state <= S_WR_TID;
                    end else begin
                        state <= type_last ? S_ACK : S_DRAIN;
                    end
                end
                S_WR_TID:  state <= S_WR_PID;
                S_WR_PID:  state <= (nargs == '0) ? S_WR_HDR : S_ARG_FLAG;
                S_ARG_FLAG: if (in_valid) state <= S_ARG_VAL;
                S_ARG_VAL: state <= (arg_idx == nargs - 1'b1) ? S_WR_HDR : S_ARG_FLAG;
                S_WR_HDR: begin
                    gen_cnt <= gen_cnt + 1'b1;
                    state   <= S_FLUSH;
                end
                S_DRAIN:   if (in_valid && in_last) state <= S_FLUSH;
                // Lets the header write land before the acknowledge
                S_FLUSH:   state <= S_ACK;
                S_ACK:     if (out_ready) state <= S_HEADER;
                default:   state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            S_HEADER: begin
                src     <= in_src;
                nargs   <= in_data[`NUM_ARGS_OFFSET +: 4];
                arg_idx <= '0;
                task_id <= {`GEN_ID_PREFIX, gen_cnt};
            end
            S_TASK_ID:  if (in_valid) task_id <= in_data;
            S_PARENT:   parent_id <= in_data;
            S_TYPE:     type_last <= in_last;
            S_SELECT:   ack_ok <= fits[sel_acc];
            S_ARG_FLAG: arg_buf <= in_data;
            S_ARG_VAL:  arg_idx <= arg_idx + 1'b1;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/task_scheduler.sv
// Task scheduler top level
`timescale 1ns/10ps
`default_nettype none

`include "sched_settings.svh"

module task_scheduler (
    input  wire                        clk,
    input  wire                        rstn,
    input  wire sched_pkg::word_t      in_data,
    input  wire                        in_valid,
    input  wire                        in_last,
    input  wire sched_pkg::acc_id_t    in_src,
    output logic                       in_ready,
    output sched_pkg::word_t           out_data,
    output logic                       out_valid,
    input  wire                        out_ready,
    output sched_pkg::acc_id_t         out_dest,
    output logic [$bits(sched_pkg::acc_id_t)+$bits(sched_pkg::slot_idx_t)-1:0] cmdq_addr,
    output logic                       cmdq_en,
    output sched_pkg::word_t           cmdq_din,
    input  wire                        retire_valid,
    input  wire sched_pkg::acc_id_t    retire_acc,
    input  wire sched_pkg::slot_cnt_t  retire_slots,
    output logic                       nempty_write,
    output sched_pkg::acc_id_t         nempty_acc
);

    wire                       sel_req;
    wire sched_pkg::word_t     sel_type;
    wire sched_pkg::acc_id_t   sel_acc;
    wire                       reserve_req;
    wire sched_pkg::acc_id_t   reserve_acc;
    wire sched_pkg::slot_cnt_t reserve_slots;
    wire                       cmd_start;
    wire                       word_valid;
    wire sched_pkg::word_t     word_data;
    wire                       cmd_done;
    wire sched_pkg::word_t     cmd_header;

    // One bit and one write index per subqueue
    wire [`NUM_ACCS-1:0]       fits;
    wire sched_pkg::slot_idx_t base_idx [`NUM_ACCS];

    task_dispatcher u_dispatcher (
        .clk(clk), .rstn(rstn),
        .in_data(in_data), .in_valid(in_valid), .in_last(in_last), .in_src(in_src),
        .in_ready(in_ready),
        .out_data(out_data), .out_valid(out_valid), .out_ready(out_ready), .out_dest(out_dest),
        .sel_req(sel_req), .sel_type(sel_type), .sel_acc(sel_acc),
        .reserve_req(reserve_req), .reserve_acc(reserve_acc), .reserve_slots(reserve_slots),
        .fits(fits),
        .cmd_start(cmd_start), .word_valid(word_valid), .word_data(word_data),
        .cmd_done(cmd_done), .cmd_header(cmd_header)
    );

    acc_selector u_selector (
        .clk(clk), .rstn(rstn),
        .sel_req(sel_req), .sel_type(sel_type), .sel_acc(sel_acc)
    );

    for (genvar a = 0; a < `NUM_ACCS; a++) begin : g_tracker
        subqueue_tracker #(.ACC_NUM(a)) u_tracker (
            .clk(clk), .rstn(rstn),
            .reserve_req(reserve_req), .reserve_acc(reserve_acc),
            .reserve_slots(reserve_slots),
            .retire_valid(retire_valid), .retire_acc(retire_acc),
            .retire_slots(retire_slots),
            .fits(fits[a]), .base_idx(base_idx[a])
        );
    end

    cmd_queue_writer u_writer (
        .clk(clk), .rstn(rstn),
        .cmd_start(cmd_start), .reserve_acc(reserve_acc), .base_idx(base_idx),
        .word_valid(word_valid), .word_data(word_data),
        .cmd_done(cmd_done), .cmd_header(cmd_header),
        .cmdq_addr(cmdq_addr), .cmdq_en(cmdq_en), .cmdq_din(cmdq_din),
        .nempty_write(nempty_write), .nempty_acc(nempty_acc)
    );

endmodule

`default_nettype wire

//--- sim/tb_clock.sv
// Testbench clock and reset
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Release happens on a falling edge, away from the sampling edge
    initial begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
    end

endmodule

`default_nettype wire

//--- sim/task_scheduler_tb.sv
// Task scheduler testbench
`timescale 1ns/10ps
`default_nettype none

`include "sched_settings.svh"

module task_scheduler_tb;

    localparam int NUM_ROWS   = 13;
    localparam int CLK_PERIOD = 20;
    localparam int ADDR_W     = $bits(sched_pkg::acc_id_t) + $bits(sched_pkg::slot_idx_t);

    typedef struct packed {
        int                   type_sel;
        int                   nargs;
        logic                 id_given;
        sched_pkg::word_t     id;
        int                   ready_delay;
        logic                 ret_en;
        int                   ret_acc;
        int                   ret_slots;
        sched_pkg::ack_t      exp_ack;
        sched_pkg::acc_id_t   exp_acc;
        sched_pkg::slot_idx_t exp_base;
    } row_t;

    wire                        clk;
    wire                        rstn;
    sched_pkg::word_t           in_data;
    logic                       in_valid;
    logic                       in_last;
    sched_pkg::acc_id_t         in_src;
    wire                        in_ready;
    wire sched_pkg::word_t      out_data;
    wire                        out_valid;
    logic                       out_ready;
    wire sched_pkg::acc_id_t    out_dest;
    wire [ADDR_W-1:0]           cmdq_addr;
    wire                        cmdq_en;
    wire sched_pkg::word_t      cmdq_din;
    logic                       retire_valid;
    sched_pkg::acc_id_t         retire_acc;
    sched_pkg::slot_cnt_t       retire_slots;
    wire                        nempty_write;
    wire sched_pkg::acc_id_t    nempty_acc;

    row_t                 rows [NUM_ROWS];
    logic [ADDR_W-1:0]    wr_addr_q [$];
    sched_pkg::word_t     wr_data_q [$];
    sched_pkg::acc_id_t   nempty_q [$];
    logic [31:0]          rng_state = 32'hc5ea3ad1;
    int                   n_checks = 0;
    int                   n_mismatch = 0;
    int                   n_fail = 0;

    // Reference model state
    int free_cnt [`NUM_ACCS];
    int ring_idx [`NUM_ACCS];
    int rr_off [`NUM_ACC_TYPES];
    int gen_cnt;

    tb_clock #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(3)) u_clock (.clk(clk), .rstn(rstn));

    task_scheduler uut (
        .clk(clk), .rstn(rstn),
        .in_data(in_data), .in_valid(in_valid), .in_last(in_last), .in_src(in_src),
        .in_ready(in_ready),
        .out_data(out_data), .out_valid(out_valid), .out_ready(out_ready), .out_dest(out_dest),
        .cmdq_addr(cmdq_addr), .cmdq_en(cmdq_en), .cmdq_din(cmdq_din),
        .retire_valid(retire_valid), .retire_acc(retire_acc), .retire_slots(retire_slots),
        .nempty_write(nempty_write), .nempty_acc(nempty_acc)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic report_error(input string msg);
        n_fail++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    task automatic check_ack(input sched_pkg::ack_t got, input sched_pkg::ack_t exp,
                             input string what);
        n_checks++;
        if (got !== exp) begin
            n_mismatch++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_acc(input sched_pkg::acc_id_t got, input sched_pkg::acc_id_t exp,
                             input string what);
        n_checks++;
        if (got !== exp) begin
            n_mismatch++;
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_write(input sched_pkg::acc_id_t acc, input sched_pkg::slot_idx_t slot,
                               input sched_pkg::word_t data, input logic [ADDR_W-1:0] got_addr,
                               input sched_pkg::word_t got_data);
        n_checks++;
        if (got_addr !== {acc, slot} || got_data !== data) begin
            n_mismatch++;
            $display("MISMATCH at %0t: queue write got %h at %h expected %h at %h",
                     $time, got_data, got_addr, data, {acc, slot});
        end
    endtask

    // Presents one word and holds it until the DUT takes it
    task automatic send_word(input sched_pkg::word_t data, input logic last);
        in_data  = data;
        in_valid = 1'b1;
        in_last  = last;
        while (in_ready !== 1'b1) @(negedge clk);
        @(negedge clk);
        in_valid = 1'b0;
        in_last  = 1'b0;
    endtask

    task automatic run_row(input int r);
        row_t                 row;
        sched_pkg::acc_id_t   src;
        sched_pkg::acc_id_t   m_acc;
        sched_pkg::slot_idx_t m_base;
        sched_pkg::ack_t      m_ack;
        sched_pkg::word_t     exp_words [$];
        sched_pkg::slot_idx_t exp_slots [$];
        sched_pkg::word_t     args [$];
        sched_pkg::word_t     parent;
        sched_pkg::word_t     word;
        sched_pkg::word_t     first_out;
        int                   need;
        row = rows[r];
        src = sched_pkg::acc_id_t'(r);
        @(negedge clk);
        if (row.ret_en) begin
            retire_valid = 1'b1;
            retire_acc   = sched_pkg::acc_id_t'(row.ret_acc);
            retire_slots = sched_pkg::slot_cnt_t'(row.ret_slots);
            free_cnt[row.ret_acc] += row.ret_slots;
            @(negedge clk);
            retire_valid = 1'b0;
        end

        // Round-robin choice within the type, then room check on the chosen ring
        if (row.type_sel == 0) begin
            m_acc = sched_pkg::acc_id_t'(`TYPE0_BASE + rr_off[0]);
            rr_off[0] = (rr_off[0] + 1) % `TYPE0_COUNT;
        end else begin
            m_acc = sched_pkg::acc_id_t'(`TYPE1_BASE + rr_off[1]);
            rr_off[1] = (rr_off[1] + 1) % `TYPE1_COUNT;
        end
        need   = `HEADER_SLOTS + 2 * row.nargs;
        m_base = sched_pkg::slot_idx_t'(ring_idx[m_acc]);
        m_ack  = (need <= `SUBQUEUE_LEN && need <= free_cnt[m_acc]) ?
                 `ACK_OK_CODE : `ACK_REJECT_CODE;
        if (m_ack != row.exp_ack || m_acc != row.exp_acc || m_base != row.exp_base) begin
            report_error($sformatf("reference model disagrees with table row %0d", r));
        end

        parent = {32'h0, next_rand()};
        for (int k = 0; k < row.nargs; k++) args.push_back({next_rand(), next_rand()});
        if (m_ack == `ACK_OK_CODE) begin
            exp_words.push_back(row.id_given ? row.id : {`GEN_ID_PREFIX, 32'(gen_cnt)});
            exp_words.push_back(parent);
            for (int k = 0; k < row.nargs; k++) begin
                word = '0;
                word[`ARG_IDX_OFFSET +: 4]  = 4'(k);
                word[`ARG_FLAG_OFFSET +: 2] = `DEFAULT_ARG_FLAGS;
                exp_words.push_back(word);
                exp_words.push_back(args[k]);
            end
            for (int i = 0; i < exp_words.size(); i++) begin
                exp_slots.push_back(m_base + sched_pkg::slot_idx_t'(i + 1));
            end
            word = '0;
            word[`CMD_TYPE_OFFSET +: 8] = `CMD_TYPE_EXEC;
            word[`NUM_ARGS_OFFSET +: 4] = 4'(row.nargs);
            word[`ENTRY_VALID_BIT]      = 1'b1;
            exp_words.push_back(word);
            exp_slots.push_back(m_base);
            free_cnt[m_acc] -= need;
            ring_idx[m_acc] = (ring_idx[m_acc] + need) % `SUBQUEUE_LEN;
            gen_cnt++;
        end

        in_src = src;
        word = '0;
        word[`NUM_ARGS_OFFSET +: 4]  = 4'(row.nargs);
        word[`TASK_ID_GIVEN_BIT]     = row.id_given;
        send_word(word, 1'b0);
        if (row.id_given) send_word(row.id, 1'b0);
        send_word(parent, 1'b0);
        send_word(row.type_sel == 0 ? `TYPE0_CODE : `TYPE1_CODE, row.nargs == 0);
        for (int k = 0; k < row.nargs; k++) send_word(args[k], k == row.nargs - 1);

        while (out_valid !== 1'b1) @(negedge clk);
        check_ack(out_data[7:0], m_ack, "acknowledge code");
        check_acc(out_dest, src, "acknowledge destination");
        // Acknowledge is a single byte in an otherwise zero word
        n_checks++;
        if (out_data[63:8] !== '0) begin
            n_mismatch++;
            $display("MISMATCH at %0t: acknowledge upper bits got %h expected 0",
                     $time, out_data[63:8]);
        end
        first_out = out_data;
        repeat (row.ready_delay) begin
            @(negedge clk);
            if (out_valid !== 1'b1) report_error("out_valid dropped while out_ready was low");
            if (out_data !== first_out) report_error("out_data changed while out_ready was low");
            if (in_ready !== 1'b0) report_error("in_ready rose while the acknowledge waited");
        end
        out_ready = 1'b1;
        @(negedge clk);
        out_ready = 1'b0;
        if (out_valid !== 1'b0) report_error("out_valid stayed high after the acknowledge");

        if (wr_data_q.size() != exp_words.size()) begin
            report_error($sformatf("row %0d made %0d queue writes instead of %0d",
                                   r, wr_data_q.size(), exp_words.size()));
        end else begin
            for (int i = 0; i < exp_words.size(); i++) begin
                check_write(m_acc, exp_slots[i], exp_words[i], wr_addr_q[i], wr_data_q[i]);
            end
        end
        if (nempty_q.size() != (m_ack == `ACK_OK_CODE ? 1 : 0)) begin
            report_error($sformatf("row %0d gave %0d nempty pulses", r, nempty_q.size()));
        end else if (m_ack == `ACK_OK_CODE) begin
            check_acc(nempty_q[0], m_acc, "nempty accelerator");
        end
        wr_addr_q.delete();
        wr_data_q.delete();
        nempty_q.delete();
    endtask

    always @(negedge clk) begin
        if (rstn && cmdq_en) begin
            wr_addr_q.push_back(cmdq_addr);
            wr_data_q.push_back(cmdq_din);
        end
        if (rstn && nempty_write) nempty_q.push_back(nempty_acc);
    end

    initial begin
        // type, nargs, id given, id, ready delay, retire en, retire acc, retire slots,
        // expected ack, expected accelerator, expected base
        rows[0]  = '{0, 0, 1'b0, 64'h0, 0, 1'b0, 0, 0, `ACK_OK_CODE, 2'd0, 4'd0};
        rows[1]  = '{0, 2, 1'b1, 64'hab_cdef_0001, 0, 1'b0, 0, 0, `ACK_OK_CODE, 2'd1, 4'd0};
        rows[2]  = '{0, 1, 1'b0, 64'h0, 3, 1'b0, 0, 0, `ACK_OK_CODE, 2'd2, 4'd0};
        rows[3]  = '{0, 3, 1'b0, 64'h0, 0, 1'b0, 0, 0, `ACK_OK_CODE, 2'd0, 4'd3};
        rows[4]  = '{1, 4, 1'b1, 64'h42_0004, 0, 1'b0, 0, 0, `ACK_OK_CODE, 2'd3, 4'd0};
        rows[5]  = '{1, 3, 1'b0, 64'h0, 2, 1'b0, 0, 0, `ACK_REJECT_CODE, 2'd3, 4'd11};
        rows[6]  = '{1, 3, 1'b0, 64'h0, 0, 1'b1, 3, 11, `ACK_OK_CODE, 2'd3, 4'd11};
        rows[7]  = '{0, 2, 1'b0, 64'h0, 0, 1'b0, 0, 0, `ACK_OK_CODE, 2'd1, 4'd7};
        rows[8]  = '{0, 0, 1'b0, 64'h0, 0, 1'b0, 0, 0, `ACK_OK_CODE, 2'd2, 4'd5};
        rows[9]  = '{0, 1, 1'b1, 64'h99, 1, 1'b0, 0, 0, `ACK_REJECT_CODE, 2'd0, 4'd12};
        rows[10] = '{0, 0, 1'b0, 64'h0, 0, 1'b0, 0, 0, `ACK_REJECT_CODE, 2'd1, 4'd14};
        rows[11] = '{0, 0, 1'b0, 64'h0, 0, 1'b1, 0, 9, `ACK_OK_CODE, 2'd2, 4'd8};
        rows[12] = '{0, 1, 1'b0, 64'h0, 4, 1'b0, 0, 0, `ACK_OK_CODE, 2'd0, 4'd12};
        for (int a = 0; a < `NUM_ACCS; a++) begin
            free_cnt[a] = `SUBQUEUE_LEN;
            ring_idx[a] = 0;
        end
        for (int t = 0; t < `NUM_ACC_TYPES; t++) rr_off[t] = 0;
        gen_cnt      = 0;
        in_data      = '0;
        in_valid     = 1'b0;
        in_last      = 1'b0;
        in_src       = '0;
        out_ready    = 1'b0;
        retire_valid = 1'b0;
        retire_acc   = '0;
        retire_slots = '0;

        wait (rstn === 1'b1);
        if (in_ready !== 1'b0 || out_valid !== 1'b0 || cmdq_en !== 1'b0 ||
            nempty_write !== 1'b0) begin
            report_error("outputs not idle right after reset");
        end
        for (int r = 0; r < NUM_ROWS; r++) run_row(r);

        $display("checks %0d, mismatches %0d, other errors %0d", n_checks, n_mismatch, n_fail);
        if (n_mismatch == 0 && n_fail == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Generous bound of 200 cycles per task
    initial begin
        #(NUM_ROWS * 200 * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run did not finish", NUM_ROWS * 200);
        $display("checks %0d, mismatches %0d, other errors %0d", n_checks, n_mismatch, n_fail);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+logic
logic/sched_pkg.sv
logic/acc_selector.sv
logic/subqueue_tracker.sv
logic/cmd_queue_writer.sv
logic/task_dispatcher.sv
logic/task_scheduler.sv
sim/tb_clock.sv
sim/task_scheduler_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the task scheduler testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f vlog.f \
        --top-module task_scheduler_tb -o task_scheduler_sim; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/task_scheduler_sim)
sim_status=$?
printf '%s\n' "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1
